/* rv32_pkg.sv */
package rv32_pkg;

	typedef logic [31:0] rv32_word;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [6:0] {
		op_reg   = 7'b0110011,
		op_imm   = 7'b0010011,
		op_lui   = 7'b0110111,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_br    = 7'b1100011,
		op_jal   = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl
	} alu_op_t;

	typedef enum logic {
		cmp_beq,
		cmp_bne
	} cmp_op_t;

	typedef enum logic {
		alumux1_rs1,
		alumux1_pc
	} alumux1_sel_t;

	typedef enum logic {
		alumux2_rs2,
		alumux2_imm
	} alumux2_sel_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc_plus4
	} wbmux_sel_t;

	// all zero is a bubble
	typedef struct packed {
		opcode_t      opcode;
		alu_op_t      aluop;
		cmp_op_t      cmpop;
		alumux1_sel_t alumux1_sel;
		alumux2_sel_t alumux2_sel;
		wbmux_sel_t   wbmux_sel;
		reg_idx_t     src1;
		reg_idx_t     src2;
		reg_idx_t     dest;
		logic         rs1_valid;
		logic         rs2_valid;
		logic         load_regfile;
		logic         mem_read;
		logic         mem_write;
		rv32_word     imm;
	} ctrl_word_t;

	localparam rv32_word reset_pc = 32'h0000_0000;
	// addi x0, x0, 0
	localparam rv32_word nop_inst = 32'h0000_0013;

endpackage

/* pipe_reg.sv */
`timescale 1ns/1ns

module pipe_reg #(
	parameter type payload_t = rv32_pkg::rv32_word
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     load,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (load) begin
			// flush wins over new data
			q <= flush ? '0 : d;
		end
	end

endmodule

/* regfile.sv */
`timescale 1ns/1ns

module regfile (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                we,
	input  rv32_pkg::reg_idx_t  waddr,
	input  rv32_pkg::rv32_word  wdata,
	input  rv32_pkg::reg_idx_t  raddr_a,
	input  rv32_pkg::reg_idx_t  raddr_b,
	output rv32_pkg::rv32_word  rdata_a,
	output rv32_pkg::rv32_word  rdata_b
);

	// x0 has no storage
	rv32_pkg::rv32_word regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (we && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu (
	input  rv32_pkg::alu_op_t  aluop,
	input  rv32_pkg::cmp_op_t  cmpop,
	input  rv32_pkg::rv32_word a,
	input  rv32_pkg::rv32_word b,
	input  rv32_pkg::rv32_word cmp_b,
	output rv32_pkg::rv32_word f,
	output logic               br_en
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		unique case (aluop)
			rv32_pkg::alu_add: f = a + b;
			rv32_pkg::alu_sub: f = a - b;
			rv32_pkg::alu_and: f = a & b;
			rv32_pkg::alu_or:  f = a | b;
			rv32_pkg::alu_xor: f = a ^ b;
			rv32_pkg::alu_slt: f = {31'd0, $signed(a) < $signed(b)};
			rv32_pkg::alu_sll: f = a << shamt;
			rv32_pkg::alu_srl: f = a >> shamt;
			default:           f = a + b;
		endcase
	end

	// cmp_b is rs1 ^ rs2 and is zero when the operands match
	assign br_en = (cmpop == rv32_pkg::cmp_bne) ? (cmp_b != '0) : (cmp_b == '0);

endmodule

/* inst_decode.sv */
`timescale 1ns/1ns

module inst_decode (
	input  rv32_pkg::rv32_word   inst,
	output rv32_pkg::ctrl_word_t cw
);

	rv32_pkg::opcode_t opc;
	rv32_pkg::alu_op_t f3_op;
	logic [2:0] funct3;

	assign opc = rv32_pkg::opcode_t'(inst[6:0]);
	assign funct3 = inst[14:12];

	always_comb begin
		unique case (funct3)
			3'd1:    f3_op = rv32_pkg::alu_sll;
			3'd2:    f3_op = rv32_pkg::alu_slt;
			3'd4:    f3_op = rv32_pkg::alu_xor;
			3'd5:    f3_op = rv32_pkg::alu_srl;
			3'd6:    f3_op = rv32_pkg::alu_or;
			3'd7:    f3_op = rv32_pkg::alu_and;
			default: f3_op = rv32_pkg::alu_add;
		endcase
	end

	always_comb begin
		cw = '0;
		cw.opcode = opc;
		cw.src1 = inst[19:15];
		cw.src2 = inst[24:20];
		cw.dest = inst[11:7];
		unique case (opc)
			rv32_pkg::op_reg: begin
				cw.aluop = (funct3 == 3'd0 && inst[30]) ? rv32_pkg::alu_sub : f3_op;
				cw.rs1_valid = 1'b1;
				cw.rs2_valid = 1'b1;
				cw.load_regfile = 1'b1;
			end
			rv32_pkg::op_imm, rv32_pkg::op_load: begin
				cw.aluop = (opc == rv32_pkg::op_imm) ? f3_op : rv32_pkg::alu_add;
				cw.alumux2_sel = rv32_pkg::alumux2_imm;
				cw.imm = {{20{inst[31]}}, inst[31:20]};
				cw.src2 = 5'd0;
				cw.rs1_valid = 1'b1;
				cw.load_regfile = 1'b1;
				cw.mem_read = (opc == rv32_pkg::op_load);
				cw.wbmux_sel = (opc == rv32_pkg::op_load) ? rv32_pkg::wb_mem : rv32_pkg::wb_alu;
			end
			rv32_pkg::op_lui: begin
				// x0 + imm
				cw.alumux2_sel = rv32_pkg::alumux2_imm;
				cw.imm = {inst[31:12], 12'd0};
				cw.src1 = 5'd0;
				cw.src2 = 5'd0;
				cw.load_regfile = 1'b1;
			end
			rv32_pkg::op_store: begin
				cw.alumux2_sel = rv32_pkg::alumux2_imm;
				cw.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				cw.dest = 5'd0;
				cw.rs1_valid = 1'b1;
				cw.rs2_valid = 1'b1;
				cw.mem_write = 1'b1;
			end
			rv32_pkg::op_br: begin
				cw.cmpop = funct3[0] ? rv32_pkg::cmp_bne : rv32_pkg::cmp_beq;
				cw.alumux1_sel = rv32_pkg::alumux1_pc;
				cw.alumux2_sel = rv32_pkg::alumux2_imm;
				cw.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
				cw.dest = 5'd0;
				cw.rs1_valid = 1'b1;
				cw.rs2_valid = 1'b1;
			end
			rv32_pkg::op_jal: begin
				cw.alumux1_sel = rv32_pkg::alumux1_pc;
				cw.alumux2_sel = rv32_pkg::alumux2_imm;
				cw.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
				cw.src1 = 5'd0;
				cw.src2 = 5'd0;
				cw.load_regfile = 1'b1;
				cw.wbmux_sel = rv32_pkg::wb_pc_plus4;
			end
			default: cw = '0;
		endcase
	end

endmodule

/* datapath.sv */
`timescale 1ns/1ns

module datapath (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 mem_ready,
	input  rv32_pkg::rv32_word   inst,
	input  rv32_pkg::ctrl_word_t cw,
	input  rv32_pkg::rv32_word   mem_rdata,
	output rv32_pkg::rv32_word   inst_addr,
	output rv32_pkg::rv32_word   id_inst,
	output logic                 dread,
	output logic                 dwrite,
	output rv32_pkg::rv32_word   mem_address,
	output rv32_pkg::rv32_word   mem_wdata
);

	rv32_pkg::rv32_word pc;
	rv32_pkg::rv32_word ifid_inst_d;
	rv32_pkg::rv32_word ifid_pc;
	rv32_pkg::rv32_word rs1_out;
	rv32_pkg::rv32_word rs2_out;
	rv32_pkg::rv32_word rs1_in;
	rv32_pkg::rv32_word rs2_in;
	rv32_pkg::rv32_word idex_pc;
	rv32_pkg::rv32_word idex_rs1;
	rv32_pkg::rv32_word idex_rs2;
	rv32_pkg::rv32_word ex_rs1;
	rv32_pkg::rv32_word ex_rs2;
	rv32_pkg::rv32_word alu_a;
	rv32_pkg::rv32_word alu_b;
	rv32_pkg::rv32_word alu_f;
	rv32_pkg::rv32_word exmem_pc;
	rv32_pkg::rv32_word exmem_alu;
	rv32_pkg::rv32_word exmem_fwd;
	rv32_pkg::rv32_word memwb_pc;
	rv32_pkg::rv32_word memwb_alu;
	rv32_pkg::rv32_word memwb_rdata;
	rv32_pkg::rv32_word wb_data;
	rv32_pkg::ctrl_word_t idex_cw;
	rv32_pkg::ctrl_word_t exmem_cw;
	rv32_pkg::ctrl_word_t memwb_cw;
	logic br_en;
	logic redirect;
	logic stall;
	logic if_load;
	logic id_flush;

	function automatic logic fwd_hit(input rv32_pkg::reg_idx_t src, input logic src_valid,
			input rv32_pkg::ctrl_word_t w);
		return src_valid && w.load_regfile && (w.dest != 5'd0) && (w.dest == src);
	endfunction

	function automatic rv32_pkg::rv32_word wb_pick(input rv32_pkg::wbmux_sel_t sel,
			input rv32_pkg::rv32_word alu_v, input rv32_pkg::rv32_word rdata,
			input rv32_pkg::rv32_word pc_v);
		unique case (sel)
			rv32_pkg::wb_mem:      return rdata;
			rv32_pkg::wb_pc_plus4: return pc_v + 32'd4;
			default:               return alu_v;
		endcase
	endfunction

	// load in execute feeding the instruction in decode
	assign stall = idex_cw.mem_read && (fwd_hit(cw.src1, cw.rs1_valid, idex_cw) ||
		fwd_hit(cw.src2, cw.rs2_valid, idex_cw));
	assign redirect = ((idex_cw.opcode == rv32_pkg::op_br) && br_en) ||
		(idex_cw.opcode == rv32_pkg::op_jal);
	assign if_load = mem_ready && !stall;
	assign id_flush = stall || redirect;

	// fetch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= rv32_pkg::reset_pc;
		end else if (if_load) begin
			pc <= redirect ? alu_f : pc + 32'd4;
		end
	end

	assign inst_addr = pc;
	assign ifid_inst_d = redirect ? rv32_pkg::nop_inst : inst;

	pipe_reg i_ifid_inst (.clk, .arst_n, .load(if_load), .flush(1'b0),
		.d(ifid_inst_d), .q(id_inst));
	pipe_reg i_ifid_pc (.clk, .arst_n, .load(if_load), .flush(redirect),
		.d(pc), .q(ifid_pc));

	// in decode the write-back value bypasses the register file
	regfile i_regfile (.clk, .arst_n, .we(mem_ready && memwb_cw.load_regfile),
		.waddr(memwb_cw.dest), .wdata(wb_data), .raddr_a(cw.src1), .raddr_b(cw.src2),
		.rdata_a(rs1_out), .rdata_b(rs2_out));

	assign rs1_in = fwd_hit(cw.src1, cw.rs1_valid, memwb_cw) ? wb_data : rs1_out;
	assign rs2_in = fwd_hit(cw.src2, cw.rs2_valid, memwb_cw) ? wb_data : rs2_out;

	pipe_reg i_idex_pc (.clk, .arst_n, .load(mem_ready), .flush(id_flush),
		.d(ifid_pc), .q(idex_pc));
	pipe_reg i_idex_rs1 (.clk, .arst_n, .load(mem_ready), .flush(id_flush),
		.d(rs1_in), .q(idex_rs1));
	pipe_reg i_idex_rs2 (.clk, .arst_n, .load(mem_ready), .flush(id_flush),
		.d(rs2_in), .q(idex_rs2));
	pipe_reg #(.payload_t(rv32_pkg::ctrl_word_t)) i_idex_cw (.clk, .arst_n,
		.load(mem_ready), .flush(id_flush), .d(cw), .q(idex_cw));

	// execute forwarding prefers EX/MEM over MEM/WB
	always_comb begin
		ex_rs1 = idex_rs1;
		ex_rs2 = idex_rs2;
		if (fwd_hit(idex_cw.src1, idex_cw.rs1_valid, exmem_cw)) begin
			ex_rs1 = exmem_fwd;
		end else if (fwd_hit(idex_cw.src1, idex_cw.rs1_valid, memwb_cw)) begin
			ex_rs1 = wb_data;
		end
		if (fwd_hit(idex_cw.src2, idex_cw.rs2_valid, exmem_cw)) begin
			ex_rs2 = exmem_fwd;
		end else if (fwd_hit(idex_cw.src2, idex_cw.rs2_valid, memwb_cw)) begin
			ex_rs2 = wb_data;
		end
	end

	assign alu_a = (idex_cw.alumux1_sel == rv32_pkg::alumux1_pc) ? idex_pc : ex_rs1;
	assign alu_b = (idex_cw.alumux2_sel == rv32_pkg::alumux2_imm) ? idex_cw.imm : ex_rs2;

	alu i_alu (.aluop(idex_cw.aluop), .cmpop(idex_cw.cmpop), .a(alu_a), .b(alu_b),
		.cmp_b(ex_rs1 ^ ex_rs2), .f(alu_f), .br_en(br_en));

	pipe_reg i_exmem_pc (.clk, .arst_n, .load(mem_ready), .flush(1'b0),
		.d(idex_pc), .q(exmem_pc));
	pipe_reg i_exmem_alu (.clk, .arst_n, .load(mem_ready), .flush(1'b0),
		.d(alu_f), .q(exmem_alu));
	pipe_reg i_exmem_rs2 (.clk, .arst_n, .load(mem_ready), .flush(1'b0),
		.d(ex_rs2), .q(mem_wdata));
	pipe_reg #(.payload_t(rv32_pkg::ctrl_word_t)) i_exmem_cw (.clk, .arst_n,
		.load(mem_ready), .flush(1'b0), .d(idex_cw), .q(exmem_cw));

	// memory
	assign mem_address = exmem_alu;
	assign dread = exmem_cw.mem_read;
	assign dwrite = exmem_cw.mem_write;
	assign exmem_fwd = wb_pick(exmem_cw.wbmux_sel, exmem_alu, mem_rdata, exmem_pc);

	pipe_reg i_memwb_pc (.clk, .arst_n, .load(mem_ready), .flush(1'b0),
		.d(exmem_pc), .q(memwb_pc));
	pipe_reg i_memwb_alu (.clk, .arst_n, .load(mem_ready), .flush(1'b0),
		.d(exmem_alu), .q(memwb_alu));
	pipe_reg i_memwb_rdata (.clk, .arst_n, .load(mem_ready), .flush(1'b0),
		.d(mem_rdata), .q(memwb_rdata));
	pipe_reg #(.payload_t(rv32_pkg::ctrl_word_t)) i_memwb_cw (.clk, .arst_n,
		.load(mem_ready), .flush(1'b0), .d(exmem_cw), .q(memwb_cw));

	// write back
	assign wb_data = wb_pick(memwb_cw.wbmux_sel, memwb_alu, memwb_rdata, memwb_pc);

endmodule

/* rv32_core.sv */
`timescale 1ns/1ns

module rv32_core (
	input  logic               clk,
	input  logic               arst_n,
	output rv32_pkg::rv32_word inst_addr,
	input  rv32_pkg::rv32_word inst,
	input  logic               mem_ready,
	input  rv32_pkg::rv32_word mem_rdata,
	output logic               dread,
	output logic               dwrite,
	output rv32_pkg::rv32_word mem_address,
	output rv32_pkg::rv32_word mem_wdata
);

	rv32_pkg::rv32_word id_inst;
	rv32_pkg::ctrl_word_t cw;

	inst_decode i_decode (
		.inst (id_inst),
		.cw   (cw)
	);

	datapath i_datapath (
		.clk         (clk),
		.arst_n      (arst_n),
		.mem_ready   (mem_ready),
		.inst        (inst),
		.cw          (cw),
		.mem_rdata   (mem_rdata),
		.inst_addr   (inst_addr),
		.id_inst     (id_inst),
		.dread       (dread),
		.dwrite      (dwrite),
		.mem_address (mem_address),
		.mem_wdata   (mem_wdata)
	);

endmodule

/* rv32_core_assert.sv */
`timescale 1ns/1ns

module rv32_core_assert (
	input logic               clk,
	input logic               arst_n,
	input logic               mem_ready,
	input logic               dread,
	input logic               dwrite,
	input rv32_pkg::rv32_word inst_addr,
	input rv32_pkg::rv32_word mem_address,
	input rv32_pkg::rv32_word mem_wdata
);

	int fail_count = 0;

	a_one_access: assert property (@(posedge clk) disable iff (!arst_n) !(dread && dwrite))
		else begin
			fail_count++;
			$error("dread and dwrite are high together");
		end

	// memory stage frozen while the memory is busy
	a_hold: assert property (@(posedge clk) disable iff (!arst_n)
			!mem_ready |=> $stable(mem_address) && $stable(mem_wdata))
		else begin
			fail_count++;
			$error("memory-stage outputs moved while mem_ready was low");
		end

	a_reset_pc: assert property (@(posedge clk) $rose(arst_n) |-> inst_addr == rv32_pkg::reset_pc)
		else begin
			fail_count++;
			$error("inst_addr is not the reset address after reset");
		end

endmodule

bind datapath rv32_core_assert i_assert (.*);

/* rv32_core_tb.sv */
`timescale 1ns/1ns

module rv32_core_tb;

	localparam int n_inst = 60;
	localparam int last_slot = n_inst - 1;
	localparam int clk_period = 8;
	localparam int timeout_ns = n_inst * 8 * clk_period * 4;
	// funct3 per kind (0-7 reg ops, 8-12 imm ops, 13 lui, 14 lw, 15 sw, 16 beq, 17 bne)
	localparam int f3_tab [0:17] = '{0, 0, 7, 6, 4, 2, 1, 5, 0, 7, 6, 4, 2, 0, 2, 2, 0, 1};
	// imm op to the matching reg op
	localparam int imap [0:4] = '{0, 2, 3, 4, 5};

	logic clk;
	logic arst_n;
	logic mem_ready;
	logic dread;
	logic dwrite;
	rv32_pkg::rv32_word inst_addr;
	rv32_pkg::rv32_word inst;
	rv32_pkg::rv32_word mem_rdata;
	rv32_pkg::rv32_word mem_address;
	rv32_pkg::rv32_word mem_wdata;
	rv32_pkg::rv32_word imem [0:63];
	rv32_pkg::rv32_word dmem [0:63];
	int prog_kind [0:last_slot];
	int prog_rd [0:last_slot];
	int prog_rs1 [0:last_slot];
	int prog_rs2 [0:last_slot];
	rv32_pkg::rv32_word prog_imm [0:last_slot];
	rv32_pkg::rv32_word exp_st_addr [$];
	rv32_pkg::rv32_word exp_st_data [$];
	rv32_pkg::rv32_word exp_ld_addr [$];
	int st_n = 0;
	int ld_n = 0;
	int errors = 0;

	rv32_core i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.inst_addr   (inst_addr),
		.inst        (inst),
		.mem_ready   (mem_ready),
		.mem_rdata   (mem_rdata),
		.dread       (dread),
		.dwrite      (dwrite),
		.mem_address (mem_address),
		.mem_wdata   (mem_wdata)
	);

	assign inst = imem[inst_addr[7:2]];
	assign mem_rdata = dmem[mem_address[7:2]];

	function automatic rv32_pkg::rv32_word fill_word(input int a);
		return (32'(a) * 32'h0101_0101) ^ 32'hc0de_0000;
	endfunction

	function automatic rv32_pkg::rv32_word alu_ref(input int op, input rv32_pkg::rv32_word a,
			input rv32_pkg::rv32_word b);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return {31'd0, $signed(a) < $signed(b)};
			6: return a << b[4:0];
			default: return a >> b[4:0];
		endcase
	endfunction

	function automatic rv32_pkg::rv32_word encode(input int kind, input int rd, input int rs1,
			input int rs2, input rv32_pkg::rv32_word imm);
		logic [4:0] d;
		logic [4:0] s1;
		logic [4:0] s2;
		logic [2:0] f3;
		d = 5'(rd);
		s1 = 5'(rs1);
		s2 = 5'(rs2);
		f3 = (kind < 18) ? 3'(f3_tab[kind]) : 3'd0;
		if (kind < 8) begin
			return {(kind == 1) ? 7'h20 : 7'h00, s2, s1, f3, d, rv32_pkg::op_reg};
		end
		case (kind)
			8, 9, 10, 11, 12: return {imm[11:0], s1, f3, d, rv32_pkg::op_imm};
			13: return {imm[31:12], d, rv32_pkg::op_lui};
			14: return {imm[11:0], s1, f3, d, rv32_pkg::op_load};
			15: return {imm[11:5], s2, s1, f3, imm[4:0], rv32_pkg::op_store};
			16, 17: return {imm[12], imm[10:5], s2, s1, f3, imm[4:1], imm[11], rv32_pkg::op_br};
			default: return {imm[20], imm[10:1], imm[11], imm[19:12], d, rv32_pkg::op_jal};
		endcase
	endfunction

	task automatic gen_program();
		int k;
		for (int i = 0; i < last_slot; i++) begin
			// every tenth slot stores a rotating register
			prog_kind[i] = (i % 10 == 9) ? 15 : int'($urandom % 19);
			prog_rd[i] = 1 + int'($urandom % 7);
			prog_rs1[i] = int'($urandom % 8);
			prog_rs2[i] = (i % 10 == 9) ? 1 + (i / 10) % 7 : int'($urandom % 8);
			prog_imm[i] = ($urandom % 4096) - 2048;
			if (prog_kind[i] == 13) begin
				prog_imm[i] = $urandom & 32'hffff_f000;
			end else if (prog_kind[i] == 14 || prog_kind[i] == 15) begin
				prog_rs1[i] = 0;
				prog_imm[i] = ($urandom % 64) * 4;
			end else if (prog_kind[i] >= 16) begin
				k = 1 + int'($urandom % 4);
				if (i + k > last_slot) begin
					k = last_slot - i;
				end
				prog_imm[i] = 32'(k * 4);
			end
		end
		// jal x0, 0 holds the core at the end
		prog_kind[last_slot] = 18;
		prog_rd[last_slot] = 0;
		prog_rs1[last_slot] = 0;
		prog_rs2[last_slot] = 0;
		prog_imm[last_slot] = '0;
		// slots past the program hold stores that must never execute
		for (int i = 0; i < 64; i++) begin
			imem[i] = encode(15, 0, 0, 1, 32'(i * 4));
			dmem[i] = fill_word(i * 4);
		end
		for (int i = 0; i < n_inst; i++) begin
			imem[i] = encode(prog_kind[i], prog_rd[i], prog_rs1[i], prog_rs2[i], prog_imm[i]);
		end
	endtask

	task automatic run_model();
		rv32_pkg::rv32_word r [0:31];
		rv32_pkg::rv32_word mdm [0:63];
		rv32_pkg::rv32_word a;
		rv32_pkg::rv32_word b;
		rv32_pkg::rv32_word v;
		rv32_pkg::rv32_word imm;
		rv32_pkg::rv32_word addr;
		int pc;
		int k;
		int nxt;
		r = '{default: '0};
		for (int i = 0; i < 64; i++) begin
			mdm[i] = fill_word(i * 4);
		end
		pc = 0;
		while (pc != last_slot) begin
			k = prog_kind[pc];
			a = r[prog_rs1[pc]];
			b = r[prog_rs2[pc]];
			imm = prog_imm[pc];
			addr = a + imm;
			v = '0;
			nxt = pc + 1;
			if (k < 8) begin
				v = alu_ref(k, a, b);
			end else if (k < 13) begin
				v = alu_ref(imap[k - 8], a, imm);
			end else if (k == 13) begin
				v = imm;
			end else if (k == 14) begin
				v = mdm[addr[7:2]];
				exp_ld_addr.push_back(addr);
			end else if (k == 15) begin
				mdm[addr[7:2]] = b;
				exp_st_addr.push_back(addr);
				exp_st_data.push_back(b);
			end else if (k == 18) begin
				v = 32'(pc * 4 + 4);
				nxt = pc + int'(imm >> 2);
			end else if ((a == b) == (k == 16)) begin
				nxt = pc + int'(imm >> 2);
			end
			if ((k <= 14 || k == 18) && prog_rd[pc] != 0) begin
				r[prog_rd[pc]] = v;
			end
			pc = nxt;
		end
	endtask

	task automatic check_word(input string name, input rv32_pkg::rv32_word exp,
			input rv32_pkg::rv32_word act);
		if (act !== exp) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// random wait states on the data side
	initial begin
		mem_ready = 1'b1;
		forever begin
			@(posedge clk);
			mem_ready <= ($urandom % 4) != 0;
		end
	end

	always @(posedge clk) begin
		if (arst_n && mem_ready && dwrite) begin
			dmem[mem_address[7:2]] <= mem_wdata;
			if (st_n < exp_st_addr.size()) begin
				check_word("mem_address", exp_st_addr[st_n], mem_address);
				check_word("mem_wdata", exp_st_data[st_n], mem_wdata);
			end else begin
				$display("unexpected store to %h at %0t ns, the program has no more stores",
					mem_address, $time);
				errors++;
			end
			st_n++;
		end
		if (arst_n && mem_ready && dread) begin
			if (ld_n < exp_ld_addr.size()) begin
				check_word("mem_address", exp_ld_addr[ld_n], mem_address);
			end
			ld_n++;
		end
	end

	initial begin
		#(timeout_ns);
		$display("timeout: the core did not finish its %0d stores within %0d ns",
			exp_st_addr.size(), timeout_ns);
		$display("Test failed");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		void'($urandom(73419));
		gen_program();
		run_model();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		wait (st_n >= exp_st_addr.size() && ld_n >= exp_ld_addr.size());
		// let the tail drain into the final loop
		repeat (60) @(posedge clk);
		check_count("store count", exp_st_addr.size(), st_n);
		check_count("load count", exp_ld_addr.size(), ld_n);
		$display("errors: %0d from checks, %0d from assertions", errors,
			i_dut.i_datapath.i_assert.fail_count);
		if (errors == 0 && i_dut.i_datapath.i_assert.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* rv32_core.f */
rv32_pkg.sv
pipe_reg.sv
regfile.sv
alu.sv
inst_decode.sv
datapath.sv
rv32_core.sv
rv32_core_assert.sv
rv32_core_tb.sv

/* Bender.yml */
package:
  name: rv32_core

sources:
  - files:
      - rv32_pkg.sv
      - pipe_reg.sv
      - regfile.sv
      - alu.sv
      - inst_decode.sv
      - datapath.sv
      - rv32_core.sv
  - target: test
    files:
      - rv32_core_assert.sv
      - rv32_core_tb.sv
